// ==== Bender.yml ====
package:
  name: pcore_icache

dependencies: {}

sources:
  # Package first, then the RTL blocks, then the top level.
  - files:
      - hw/icache_pkg.sv
      - hw/icache_datapath.sv
      - hw/icache_controller.sv
      - hw/icache_top.sv

  # Memory model and testbench.
  - target: simulation
    files:
      - sim/tb_icache_mem.sv
      - sim/tb_icache_top.sv

// ==== hw/icache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_controller (
  input  wire  clk_i,
  input  wire  rst_ni,

  input  wire  flush_i,
  input  wire  fetch_req_i,
  input  wire  cache_hit_i,
  input  wire  mem_ack_i,

  output logic fetch_ack_o,
  output logic mem_req_o,
  output logic cache_rw_o,
  output logic cache_flush_o
);
  import icache_pkg::*;

  type_icache_state_e state_q;
  type_icache_state_e state_d;

  logic fetch_ack_q;
  logic fetch_ack_d;
  logic flush_q;
  logic flush_d;
  logic flush_pend_q;
  logic flush_pend_d;
  logic flush_now;
  logic start_lookup;

  // ------------------------------------------------------------------
  // Next state logic
  // ------------------------------------------------------------------

  assign flush_now = flush_i || flush_pend_q;

  // No new lookup while the previous ack is out or the lines are being cleared.
  assign start_lookup = fetch_req_i && !fetch_ack_q && !flush_q;

  always_comb begin
    state_d      = state_q;
    fetch_ack_d  = 1'b0;
    flush_d      = 1'b0;
    flush_pend_d = flush_pend_q;

    unique case (state_q)
      ICACHE_IDLE: begin
        if (flush_now) begin
          flush_d      = 1'b1;
          flush_pend_d = 1'b0;
        end else if (start_lookup) begin
          state_d = ICACHE_LOOKUP;
        end
      end
      ICACHE_LOOKUP: begin
        if (cache_hit_i) begin
          fetch_ack_d = 1'b1;
          state_d     = ICACHE_IDLE;
        end else begin
          state_d = ICACHE_MISS;
        end
      end
      ICACHE_MISS: begin
        if (mem_ack_i) begin
          state_d = ICACHE_REFILL;                               // Line is written this cycle.
        end
      end
      ICACHE_REFILL: begin
        state_d = ICACHE_LOOKUP;
      end
      default: begin
        state_d = ICACHE_IDLE;
      end
    endcase

    if (flush_i && (state_q != ICACHE_IDLE)) begin
      flush_pend_d = 1'b1;                                       // Served on return to idle.
    end
  end

  // ------------------------------------------------------------------
  // State registers
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= ICACHE_IDLE;
      fetch_ack_q  <= 1'b0;
      flush_q      <= 1'b0;
      flush_pend_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      fetch_ack_q  <= fetch_ack_d;
      flush_q      <= flush_d;
      flush_pend_q <= flush_pend_d;
    end
  end

  assign fetch_ack_o   = fetch_ack_q;
  assign cache_flush_o = flush_q;
  assign mem_req_o     = (state_q == ICACHE_MISS);
  assign cache_rw_o    = (state_q == ICACHE_MISS) && mem_ack_i;

endmodule

`default_nettype wire

// ==== hw/icache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_datapath (
  input  wire                                    clk_i,
  input  wire                                    rst_ni,

  input  wire                                    icache_flush_i,
  input  wire                                    cache_rw_i,

  input  wire  [icache_pkg::ICACHE_ADDR_WIDTH-1:0] if2icache_addr_i,
  input  wire  [icache_pkg::ICACHE_LINE_WIDTH-1:0] mem2icache_data_i,

  output logic                                   cache_hit_o,
  output logic [icache_pkg::ICACHE_DATA_WIDTH-1:0] icache2if_data_o
);
  import icache_pkg::*;

  localparam int WORD_SEL_BITS = ICACHE_OFFSET_BITS - 2;

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------

  logic [ICACHE_NO_OF_SETS-1:0] valid_q;
  logic [ICACHE_TAG_BITS-1:0]   tag_mem  [ICACHE_NO_OF_SETS];
  logic [ICACHE_LINE_WIDTH-1:0] line_mem [ICACHE_NO_OF_SETS];

  type_icache_line_s            rd_line;

  logic [ICACHE_TAG_BITS-1:0]   addr_tag;
  logic [ICACHE_IDX_BITS-1:0]   addr_index;
  logic [WORD_SEL_BITS-1:0]     addr_word;

  logic [ICACHE_DATA_WIDTH-1:0] data_d;
  logic [ICACHE_DATA_WIDTH-1:0] data_q;

  // ------------------------------------------------------------------
  // Address split and set read
  // ------------------------------------------------------------------

  assign addr_tag   = if2icache_addr_i[ICACHE_ADDR_WIDTH-1:ICACHE_TAG_LSB];
  assign addr_index = if2icache_addr_i[ICACHE_TAG_LSB-1:ICACHE_OFFSET_BITS];
  assign addr_word  = if2icache_addr_i[ICACHE_OFFSET_BITS-1:2];

  assign rd_line.valid     = valid_q[addr_index];
  assign rd_line.tag       = tag_mem[addr_index];
  assign rd_line.data_line = line_mem[addr_index];

  assign cache_hit_o = rd_line.valid && (rd_line.tag == addr_tag);

  // ------------------------------------------------------------------
  // Word select and fetch data register
  // ------------------------------------------------------------------

  always_comb begin
    data_d = rd_line.data_line[addr_word*ICACHE_DATA_WIDTH +: ICACHE_DATA_WIDTH];
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;                                            // Loads every cycle.
  end

  assign icache2if_data_o = data_q;

  // ------------------------------------------------------------------
  // Line write and valid bits
  // ------------------------------------------------------------------

  // A refill always makes the indexed set valid under the current tag.
  always_ff @(posedge clk_i) begin
    if (cache_rw_i) begin
      tag_mem[addr_index]  <= addr_tag;
      line_mem[addr_index] <= mem2icache_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || icache_flush_i) begin
      valid_q <= '0;                                             // Drops every line at once.
    end else if (cache_rw_i) begin
      valid_q[addr_index] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // ------------------------------------------------------------------
  // Cache geometry
  // ------------------------------------------------------------------

  localparam int ICACHE_ADDR_WIDTH  = 32;
  localparam int ICACHE_DATA_WIDTH  = 32;
  localparam int ICACHE_LINE_WIDTH  = 128;
  localparam int ICACHE_NO_OF_SETS  = 64;
  localparam int ICACHE_OFFSET_BITS = 4;                         // Byte offset within a line.
  localparam int ICACHE_IDX_BITS    = 6;
  localparam int ICACHE_TAG_LSB     = ICACHE_OFFSET_BITS + ICACHE_IDX_BITS;
  localparam int ICACHE_TAG_BITS    = ICACHE_ADDR_WIDTH - ICACHE_TAG_LSB;

  // ------------------------------------------------------------------
  // Fetch and memory port structs
  // ------------------------------------------------------------------

  typedef struct packed {
    logic                         req;                           // Held until ack is seen.
    logic [ICACHE_ADDR_WIDTH-1:0] addr;
  } type_if2icache_s;

  typedef struct packed {
    logic                         ack;                           // One-cycle pulse.
    logic [ICACHE_DATA_WIDTH-1:0] data;
  } type_icache2if_s;

  typedef struct packed {
    logic                         req;
    logic [ICACHE_ADDR_WIDTH-1:0] addr;                          // Low 4 bits are ignored.
  } type_icache2mem_s;

  typedef struct packed {
    logic                         ack;
    logic [ICACHE_LINE_WIDTH-1:0] data_line;                     // Valid while ack is high.
  } type_mem2icache_s;

  // One stored cache line.
  typedef struct packed {
    logic                         valid;
    logic [ICACHE_TAG_BITS-1:0]   tag;
    logic [ICACHE_LINE_WIDTH-1:0] data_line;
  } type_icache_line_s;

  // Controller states.
  typedef enum logic [1:0] {
    ICACHE_IDLE,
    ICACHE_LOOKUP,
    ICACHE_MISS,
    ICACHE_REFILL
  } type_icache_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  wire                          clk_i,
  input  wire                          rst_ni,

  input  wire                          flush_i,

  input  wire  icache_pkg::type_if2icache_s  if2icache_i,
  output icache_pkg::type_icache2if_s        icache2if_o,

  output icache_pkg::type_icache2mem_s       icache2mem_o,
  input  wire  icache_pkg::type_mem2icache_s mem2icache_i
);
  import icache_pkg::*;

  logic                         cache_hit;
  logic                         cache_rw;
  logic                         icache_flush;
  logic                         fetch_ack;
  logic                         mem_req;
  logic [ICACHE_DATA_WIDTH-1:0] fetch_data;

  // ------------------------------------------------------------------
  // Sequencing
  // ------------------------------------------------------------------

  icache_controller u_controller (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_req_i   (if2icache_i.req),
    .cache_hit_i   (cache_hit),
    .mem_ack_i     (mem2icache_i.ack),
    .fetch_ack_o   (fetch_ack),
    .mem_req_o     (mem_req),
    .cache_rw_o    (cache_rw),
    .cache_flush_o (icache_flush)
  );

  // ------------------------------------------------------------------
  // Storage and lookup
  // ------------------------------------------------------------------

  icache_datapath u_datapath (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .icache_flush_i    (icache_flush),
    .cache_rw_i        (cache_rw),
    .if2icache_addr_i  (if2icache_i.addr),
    .mem2icache_data_i (mem2icache_i.data_line),
    .cache_hit_o       (cache_hit),
    .icache2if_data_o  (fetch_data)
  );

  assign icache2if_o.ack  = fetch_ack;
  assign icache2if_o.data = fetch_data;

  // The fetch address is held during a miss, so memory sees it unchanged.
  assign icache2mem_o.req  = mem_req;
  assign icache2mem_o.addr = if2icache_i.addr;

endmodule

`default_nettype wire

// ==== pcore_icache.f ====
hw/icache_pkg.sv
hw/icache_datapath.sv
hw/icache_controller.sv
hw/icache_top.sv
sim/tb_icache_mem.sv
sim/tb_icache_top.sv

// ==== sim/tb_icache_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem (
  input  wire                                clk_i,
  input  wire                                rst_ni,

  input  wire  icache_pkg::type_icache2mem_s mem_req_i,
  output icache_pkg::type_mem2icache_s       mem_rsp_o
);
  import icache_pkg::*;

  localparam int                     RESP_DELAY   = 3;
  localparam int                     LINE_WORDS   = ICACHE_LINE_WIDTH / ICACHE_DATA_WIDTH;
  localparam logic [ICACHE_DATA_WIDTH-1:0] DATA_PATTERN = 32'hA5A5_0000;

  logic                         busy_q;
  int                           delay_q;
  logic [ICACHE_ADDR_WIDTH-1:0] addr_q;
  logic                         ack_q;
  logic [ICACHE_LINE_WIDTH-1:0] line_q;
  int                           req_count;                       // Read by the testbench.

  // ------------------------------------------------------------------
  // Line contents
  // ------------------------------------------------------------------

  // Every word holds its own byte address XOR the pattern.
  function automatic logic [ICACHE_LINE_WIDTH-1:0] build_line(
    input logic [ICACHE_ADDR_WIDTH-1:0] addr
  );
    logic [ICACHE_LINE_WIDTH-1:0] line;
    logic [ICACHE_ADDR_WIDTH-1:0] base_addr;
    logic [ICACHE_ADDR_WIDTH-1:0] word_addr;
    int                           i;
    base_addr = {addr[ICACHE_ADDR_WIDTH-1:ICACHE_OFFSET_BITS], {ICACHE_OFFSET_BITS{1'b0}}};
    line      = '0;
    for (i = 0; i < LINE_WORDS; i++) begin
      word_addr = base_addr + 32'(i * 4);
      line[i*ICACHE_DATA_WIDTH +: ICACHE_DATA_WIDTH] = word_addr ^ DATA_PATTERN;
    end
    return line;
  endfunction

  // ------------------------------------------------------------------
  // Request handling
  // ------------------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q    <= 1'b0;
      delay_q   <= 0;
      addr_q    <= '0;
      ack_q     <= 1'b0;
      line_q    <= '0;
      req_count <= 0;
    end else begin
      ack_q <= 1'b0;
      if (busy_q) begin
        if (delay_q == 0) begin
          ack_q  <= 1'b1;
          line_q <= build_line(addr_q);
          busy_q <= 1'b0;
        end else begin
          delay_q <= delay_q - 1;
        end
      end else if (mem_req_i.req && !ack_q) begin                // Req is still high during ack.
        busy_q    <= 1'b1;
        delay_q   <= RESP_DELAY - 1;
        addr_q    <= mem_req_i.addr;
        req_count <= req_count + 1;
      end
    end
  end

  assign mem_rsp_o.ack       = ack_q;
  assign mem_rsp_o.data_line = line_q;

endmodule

`default_nettype wire

// ==== sim/tb_icache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_icache_top;
  import icache_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 8;
  localparam int NUM_TESTS       = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST;
  localparam int FETCH_LIMIT     = 50;
  localparam int HIT_LATENCY     = 2;
  localparam int RANDOM_FETCHES  = 40;

  localparam logic [31:0] LINE_A_ADDR   = 32'h0000_1230;
  localparam logic [31:0] CONFLICT_ADDR = 32'h0004_5230;         // Same index, other tag.
  localparam logic [ICACHE_TAG_BITS-1:0] TAG_A = 22'h00011;
  localparam logic [ICACHE_TAG_BITS-1:0] TAG_B = 22'h2C0D5;
  localparam logic [ICACHE_IDX_BITS-1:0] RAND_SET_BASE = 6'd40;

  logic             clk = 1'b0;
  logic             rst_n;
  logic             flush;
  type_if2icache_s  fetch_if;
  type_icache2if_s  fetch_rsp;
  type_icache2mem_s mem_req;
  type_mem2icache_s mem_rsp;

  integer seed;
  string  test_name;
  int     test_err_start;
  int     error_count;
  int     check_count;
  int     tests_run;
  int     tests_failed;

  // ------------------------------------------------------------------
  // DUT and memory model
  // ------------------------------------------------------------------

  icache_top UUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush),
    .if2icache_i  (fetch_if),
    .icache2if_o  (fetch_rsp),
    .icache2mem_o (mem_req),
    .mem2icache_i (mem_rsp)
  );

  tb_icache_mem u_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("ERROR %s: %s expected %h, actual %h", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic start_test(input string name);
    test_name      = name;
    test_err_start = error_count;
    tests_run++;
  endtask

  task automatic finish_test();
    if (error_count == test_err_start) begin
      $display("%s: PASS", test_name);
    end else begin
      $display("%s: FAIL with %0d errors", test_name, error_count - test_err_start);
      tests_failed++;
    end
  endtask

  task automatic pulse_flush();
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // Latency counts cycles from the edge that samples req to the ack cycle.
  task automatic fetch_word(input logic [31:0] addr, output logic [31:0] data,
                            output int latency, output bit acked);
    int waited;
    waited  = 0;
    acked   = 1'b0;
    data    = '0;
    latency = 0;
    @(posedge clk);
    fetch_if.req  <= 1'b1;
    fetch_if.addr <= addr;
    while (!acked && waited < FETCH_LIMIT) begin
      @(negedge clk);
      waited++;
      if (mem_req.req) begin
        check("memory address", addr, mem_req.addr);
      end
      if (fetch_rsp.ack) begin
        acked   = 1'b1;
        data    = fetch_rsp.data;
        latency = waited - 1;
      end
    end
    @(posedge clk);
    fetch_if.req <= 1'b0;
    if (!acked) begin
      $display("%s: fetch of address %h got no acknowledge within %0d cycles",
               test_name, addr, FETCH_LIMIT);
      error_count++;
    end
  endtask

  // ------------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------------

  task automatic cold_miss_test();
    logic [31:0] data;
    int          lat;
    bit          ok;
    int          count_before;
    start_test("cold_miss");
    count_before = u_mem.req_count;
    fetch_word(LINE_A_ADDR + 32'h8, data, lat, ok);
    if (ok) check("data", expected_word(LINE_A_ADDR + 32'h8), data);
    check("memory requests", count_before + 1, u_mem.req_count);
    finish_test();
  endtask

  task automatic hit_select_test();
    logic [31:0] data;
    logic [31:0] addr;
    int          lat;
    bit          ok;
    int          count_before;
    int          i;
    start_test("hit_word_select");
    count_before = u_mem.req_count;
    for (i = 0; i < 4; i++) begin
      addr = LINE_A_ADDR + 32'(i * 4);
      fetch_word(addr, data, lat, ok);
      if (ok) begin
        check("data", expected_word(addr), data);
        check("ack latency", HIT_LATENCY, lat);
      end
    end
    check("memory requests", count_before, u_mem.req_count);
    finish_test();
  endtask

  task automatic conflict_test();
    logic [31:0] data;
    int          lat;
    bit          ok;
    int          count_before;
    start_test("conflict_eviction");
    count_before = u_mem.req_count;
    fetch_word(CONFLICT_ADDR + 32'hC, data, lat, ok);
    if (ok) check("data", expected_word(CONFLICT_ADDR + 32'hC), data);
    fetch_word(LINE_A_ADDR, data, lat, ok);
    if (ok) check("data", expected_word(LINE_A_ADDR), data);
    check("memory requests", count_before + 2, u_mem.req_count);
    finish_test();
  endtask

  task automatic flush_test();
    logic [31:0] data;
    int          lat;
    bit          ok;
    int          count_before;
    start_test("flush");
    pulse_flush();
    count_before = u_mem.req_count;
    fetch_word(LINE_A_ADDR + 32'h4, data, lat, ok);
    if (ok) check("data", expected_word(LINE_A_ADDR + 32'h4), data);
    check("memory requests", count_before + 1, u_mem.req_count);
    finish_test();
  endtask

  task automatic random_test();
    bit                         valid_model [ICACHE_NO_OF_SETS];
    logic [ICACHE_TAG_BITS-1:0] tag_model   [ICACHE_NO_OF_SETS];
    logic [ICACHE_TAG_BITS-1:0] tag;
    logic [ICACHE_IDX_BITS-1:0] set;
    logic [31:0]                rnd;
    logic [31:0]                addr;
    logic [31:0]                data;
    int                         lat;
    bit                         ok;
    int                         misses;
    int                         count_before;
    int                         i;
    start_test("random_sequence");
    pulse_flush();                                               // Start from an empty cache.
    for (i = 0; i < ICACHE_NO_OF_SETS; i++) begin
      valid_model[i] = 1'b0;
      tag_model[i]   = '0;
    end
    misses       = 0;
    count_before = u_mem.req_count;
    for (i = 0; i < RANDOM_FETCHES; i++) begin
      rnd  = $random(seed);
      set  = RAND_SET_BASE + ICACHE_IDX_BITS'(rnd[2:0]);
      tag  = rnd[3] ? TAG_B : TAG_A;
      addr = {tag, set, rnd[5:4], 2'b00};
      if (!(valid_model[set] && tag_model[set] == tag)) begin
        misses++;
        valid_model[set] = 1'b1;
        tag_model[set]   = tag;
      end
      fetch_word(addr, data, lat, ok);
      if (ok) check("data", expected_word(addr), data);
    end
    check("memory requests", count_before + misses, u_mem.req_count);
    finish_test();
  endtask

  // ------------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------------

  initial begin
    seed          = 32'h4e6e;
    error_count   = 0;
    check_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    rst_n         = 1'b0;
    flush         = 1'b0;
    fetch_if.req  = 1'b0;
    fetch_if.addr = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    cold_miss_test();
    hit_select_test();
    conflict_test();
    flush_test();
    random_test();

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
